//--- verilog/periph_macros.svh
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

////////////////////
// Bus geometry
////////////////////

`define PERIPH_ADDR_W        15
// Slave select field sits at paddr[14:12]
`define PERIPH_SEL_LSB       12
`define PERIPH_SEL_W         3
`define PERIPH_OFFSET_W      12
`define PERIPH_DATA_W        32
`define PERIPH_NUM_IRQ       32

// Boot address after reset
`define PERIPH_BOOT_ADDR_RST 32'h8000

// Event vector bit positions
`define PERIPH_IRQ_TIMER     31
`define PERIPH_IRQ_GPIO      30

// Clock enable bit positions in CLKGATE
`define PERIPH_CG_GPIO       0
`define PERIPH_CG_TIMER      1
`define PERIPH_CG_GPP        2

////////////////////
// Register offsets
////////////////////

// GPIO
`define PERIPH_GPIO_DIR       12'h000
`define PERIPH_GPIO_IN        12'h004
`define PERIPH_GPIO_OUT       12'h008
`define PERIPH_GPIO_INTEN     12'h00C
`define PERIPH_GPIO_INTSTATUS 12'h010

// Timer
`define PERIPH_TIMER_COUNT    12'h000
`define PERIPH_TIMER_CTRL     12'h004
`define PERIPH_TIMER_CMP      12'h008

// Event unit
`define PERIPH_EVENT_IER      12'h000
`define PERIPH_EVENT_IPR      12'h004
`define PERIPH_EVENT_IPS      12'h008
`define PERIPH_EVENT_ICP      12'h00C

// SoC control
`define PERIPH_SOC_PADMUX     12'h000
`define PERIPH_SOC_CLKGATE    12'h004
`define PERIPH_SOC_BOOTADDR   12'h008

`endif

//--- verilog/periph_pkg.sv
`include "periph_macros.svh"

package periph_pkg;

  // Slave index taken from paddr[14:12]
  // Values 5 to 7 have no slave behind them
  typedef enum logic [`PERIPH_SEL_W-1:0] {
    sel_gpio    = 3'd0,
    sel_timer   = 3'd1,
    sel_event   = 3'd2,
    sel_socctrl = 3'd3,
    sel_gpp     = 3'd4
  } periph_sel_e;

  // Full address seen at the APB slave port
  typedef logic [`PERIPH_ADDR_W-1:0]   apb_addr_t;

  // Register offset inside one slave
  typedef logic [`PERIPH_OFFSET_W-1:0] reg_offset_t;

  // One data word
  typedef logic [`PERIPH_DATA_W-1:0]   reg_word_t;

endpackage

//--- verilog/periph_bus.sv
`timescale 1ns/1ps

`include "periph_macros.svh"

module periph_bus import periph_pkg::*; (
  input  apb_addr_t paddr_i,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      gpp_pready_i,
  input  logic      gpp_pslverr_i,
  input  reg_word_t gpio_prdata_i,
  input  reg_word_t timer_prdata_i,
  input  reg_word_t event_prdata_i,
  input  reg_word_t soc_prdata_i,
  input  reg_word_t gpp_prdata_i,
  output logic      gpio_psel_o,
  output logic      timer_psel_o,
  output logic      event_psel_o,
  output logic      soc_psel_o,
  output logic      gpp_psel_o,
  output reg_word_t prdata_o,
  output logic      pready_o,
  output logic      pslverr_o
);

  periph_sel_e sel;

  // Slave field of the address
  assign sel = periph_sel_e'(paddr_i[`PERIPH_SEL_LSB +: `PERIPH_SEL_W]);

  ////////////////////
  // Select and return mux
  ////////////////////

  always_comb begin
    // Defaults cover the internal slaves: always ready, never an error
    gpio_psel_o  = 1'b0;
    timer_psel_o = 1'b0;
    event_psel_o = 1'b0;
    soc_psel_o   = 1'b0;
    gpp_psel_o   = 1'b0;
    prdata_o     = '0;
    pready_o     = 1'b1;
    pslverr_o    = 1'b0;

    case (sel)
      sel_gpio: begin
        gpio_psel_o = psel_i;
        prdata_o    = gpio_prdata_i;
      end
      sel_timer: begin
        timer_psel_o = psel_i;
        prdata_o     = timer_prdata_i;
      end
      sel_event: begin
        event_psel_o = psel_i;
        prdata_o     = event_prdata_i;
      end
      sel_socctrl: begin
        soc_psel_o = psel_i;
        prdata_o   = soc_prdata_i;
      end
      sel_gpp: begin
        // External slave may stretch the access phase
        gpp_psel_o = psel_i;
        prdata_o   = gpp_prdata_i;
        pready_o   = gpp_pready_i;
        pslverr_o  = psel_i & penable_i & gpp_pslverr_i;
      end
      default: begin
        // Unmapped: finish in the first access cycle with an error
        pslverr_o = psel_i & penable_i;
      end
    endcase
  end

endmodule

//--- verilog/apb_gpio.sv
`timescale 1ns/1ps

`include "periph_macros.svh"

module apb_gpio import periph_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        en_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  reg_offset_t paddr_i,
  input  reg_word_t   pwdata_i,
  input  reg_word_t   gpio_in_i,
  output reg_word_t   prdata_o,
  output reg_word_t   gpio_out_o,
  output reg_word_t   gpio_dir_o,
  output logic        event_o
);

  logic      wr_en;
  reg_word_t sync1_q;
  reg_word_t sync2_q;
  reg_word_t prev_q;
  reg_word_t dir_q;
  reg_word_t out_q;
  reg_word_t inten_q;
  reg_word_t status_q;
  reg_word_t status_set;
  reg_word_t status_clr;

  assign wr_en = psel_i & penable_i & pwrite_i;

  ////////////////////
  // Interrupt status
  ////////////////////

  // Rising edge of the synchronized pin, only counted while enabled
  assign status_set = en_i ? (sync2_q & ~prev_q & inten_q) : '0;

  // Write one to clear
  assign status_clr = (wr_en && paddr_i == `PERIPH_GPIO_INTSTATUS) ? pwdata_i : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q  <= '0;
      sync2_q  <= '0;
      prev_q   <= '0;
      dir_q    <= '0;
      out_q    <= '0;
      inten_q  <= '0;
      status_q <= '0;
    end else begin
      // Two-flop synchronizer plus edge history, frozen when gated off
      if (en_i) begin
        sync1_q <= gpio_in_i;
        sync2_q <= sync1_q;
        prev_q  <= sync2_q;
      end
      if (wr_en) begin
        case (paddr_i)
          `PERIPH_GPIO_DIR:   dir_q   <= pwdata_i;
          `PERIPH_GPIO_OUT:   out_q   <= pwdata_i;
          `PERIPH_GPIO_INTEN: inten_q <= pwdata_i;
          default: ;
        endcase
      end
      // A new edge beats a clear in the same cycle
      status_q <= (status_q & ~status_clr) | status_set;
    end
  end

  ////////////////////
  // Read mux
  ////////////////////

  always_comb begin
    case (paddr_i)
      `PERIPH_GPIO_DIR:       prdata_o = dir_q;
      `PERIPH_GPIO_IN:        prdata_o = sync2_q;
      `PERIPH_GPIO_OUT:       prdata_o = out_q;
      `PERIPH_GPIO_INTEN:     prdata_o = inten_q;
      `PERIPH_GPIO_INTSTATUS: prdata_o = status_q;
      default:                prdata_o = '0;
    endcase
  end

  assign gpio_out_o = out_q;
  assign gpio_dir_o = dir_q;

  // Level interrupt while any status bit is pending
  assign event_o = |status_q;

endmodule

//--- verilog/apb_timer.sv
`timescale 1ns/1ps

`include "periph_macros.svh"

module apb_timer import periph_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        en_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  reg_offset_t paddr_i,
  input  reg_word_t   pwdata_i,
  output reg_word_t   prdata_o,
  output logic        event_o
);

  logic      wr_en;
  logic      run_q;
  logic      tick;
  logic      cmp_hit;
  reg_word_t count_q;
  reg_word_t cmp_q;

  assign wr_en = psel_i & penable_i & pwrite_i;

  // Counter advances only when running and its clock enable is set
  assign tick    = run_q & en_i;
  assign cmp_hit = tick & (count_q == cmp_q);

  ////////////////////
  // Counter and registers
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
      run_q   <= 1'b0;
      cmp_q   <= '0;
    end else begin
      // Software write to COUNT takes priority over counting
      if (wr_en && paddr_i == `PERIPH_TIMER_COUNT) begin
        count_q <= pwdata_i;
      end else if (cmp_hit) begin
        count_q <= '0;
      end else if (tick) begin
        count_q <= count_q + 32'd1;
      end
      if (wr_en && paddr_i == `PERIPH_TIMER_CTRL) begin
        run_q <= pwdata_i[0];
      end
      if (wr_en && paddr_i == `PERIPH_TIMER_CMP) begin
        cmp_q <= pwdata_i;
      end
    end
  end

  ////////////////////
  // Read mux
  ////////////////////

  always_comb begin
    case (paddr_i)
      `PERIPH_TIMER_COUNT: prdata_o = count_q;
      `PERIPH_TIMER_CTRL:  prdata_o = {31'd0, run_q};
      `PERIPH_TIMER_CMP:   prdata_o = cmp_q;
      default:             prdata_o = '0;
    endcase
  end

  // One-cycle strobe on the match cycle
  assign event_o = cmp_hit;

endmodule

//--- verilog/apb_event_unit.sv
`timescale 1ns/1ps

`include "periph_macros.svh"

module apb_event_unit import periph_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  reg_offset_t paddr_i,
  input  reg_word_t   pwdata_i,
  input  reg_word_t   events_i,
  output reg_word_t   prdata_o,
  output reg_word_t   irq_o
);

  logic                       wr_en;
  logic [`PERIPH_NUM_IRQ-1:0] ier_q;
  logic [`PERIPH_NUM_IRQ-1:0] pending_q;
  logic [`PERIPH_NUM_IRQ-1:0] pending_d;
  logic [`PERIPH_NUM_IRQ-1:0] ier_d;
  logic [`PERIPH_NUM_IRQ-1:0] sw_set;
  logic [`PERIPH_NUM_IRQ-1:0] sw_clr;
  logic [`PERIPH_NUM_IRQ-1:0] irq_q;

  assign wr_en = psel_i & penable_i & pwrite_i;

  ////////////////////
  // Pending logic
  ////////////////////

  assign sw_set = (wr_en && paddr_i == `PERIPH_EVENT_IPS) ? pwdata_i : '0;
  assign sw_clr = (wr_en && paddr_i == `PERIPH_EVENT_ICP) ? pwdata_i : '0;
  assign ier_d  = (wr_en && paddr_i == `PERIPH_EVENT_IER) ? pwdata_i : ier_q;

  // Hardware source applied last so it beats a clear in the same cycle
  assign pending_d = ((pending_q | sw_set) & ~sw_clr) | events_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ier_q     <= '0;
      pending_q <= '0;
      irq_q     <= '0;
    end else begin
      ier_q     <= ier_d;
      pending_q <= pending_d;
      // Registered mask, moves in step with pending
      irq_q     <= pending_d & ier_d;
    end
  end

  ////////////////////
  // Read mux
  ////////////////////

  always_comb begin
    case (paddr_i)
      `PERIPH_EVENT_IER: prdata_o = ier_q;
      `PERIPH_EVENT_IPR: prdata_o = pending_q;
      // IPS and ICP are write only
      default:           prdata_o = '0;
    endcase
  end

  assign irq_o = irq_q;

endmodule

//--- verilog/apb_soc_ctrl.sv
`timescale 1ns/1ps

`include "periph_macros.svh"

module apb_soc_ctrl import periph_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  reg_offset_t paddr_i,
  input  reg_word_t   pwdata_i,
  output reg_word_t   prdata_o,
  output reg_word_t   pad_mux_o,
  output reg_word_t   clk_gate_o,
  output reg_word_t   boot_addr_o
);

  logic      wr_en;
  reg_word_t pad_mux_q;
  reg_word_t clk_gate_q;
  reg_word_t boot_addr_q;

  assign wr_en = psel_i & penable_i & pwrite_i;

  ////////////////////
  // Control registers
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pad_mux_q   <= '0;
      // All peripherals start clocked
      clk_gate_q  <= '1;
      boot_addr_q <= `PERIPH_BOOT_ADDR_RST;
    end else if (wr_en) begin
      case (paddr_i)
        `PERIPH_SOC_PADMUX:   pad_mux_q   <= pwdata_i;
        `PERIPH_SOC_CLKGATE:  clk_gate_q  <= pwdata_i;
        `PERIPH_SOC_BOOTADDR: boot_addr_q <= pwdata_i;
        default: ;
      endcase
    end
  end

  // Unknown offsets read as zero
  always_comb begin
    case (paddr_i)
      `PERIPH_SOC_PADMUX:   prdata_o = pad_mux_q;
      `PERIPH_SOC_CLKGATE:  prdata_o = clk_gate_q;
      `PERIPH_SOC_BOOTADDR: prdata_o = boot_addr_q;
      default:              prdata_o = '0;
    endcase
  end

  assign pad_mux_o   = pad_mux_q;
  assign clk_gate_o  = clk_gate_q;
  assign boot_addr_o = boot_addr_q;

endmodule

//--- verilog/peripherals.sv
`timescale 1ns/1ps

`include "periph_macros.svh"

module peripherals import periph_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  // APB slave port
  input  apb_addr_t   paddr_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  reg_word_t   pwdata_i,
  output reg_word_t   prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  // GPIO pins
  input  reg_word_t   gpio_in_i,
  output reg_word_t   gpio_out_o,
  output reg_word_t   gpio_dir_o,
  // SoC side
  output reg_word_t   irq_o,
  output reg_word_t   pad_mux_o,
  output reg_word_t   boot_addr_o,
  // General purpose port
  output reg_offset_t gpp_paddr_o,
  output reg_word_t   gpp_pwdata_o,
  output logic        gpp_pwrite_o,
  output logic        gpp_psel_o,
  output logic        gpp_penable_o,
  output logic        gpp_clk_en_o,
  input  reg_word_t   gpp_prdata_i,
  input  logic        gpp_pready_i,
  input  logic        gpp_pslverr_i
);

  reg_offset_t offset;
  logic        gpio_psel;
  logic        timer_psel;
  logic        event_psel;
  logic        soc_psel;
  logic        gpp_psel;
  reg_word_t   gpio_prdata;
  reg_word_t   timer_prdata;
  reg_word_t   event_prdata;
  reg_word_t   soc_prdata;
  reg_word_t   clk_gate;
  reg_word_t   event_src;
  logic        gpio_event;
  logic        timer_event;

  // Offset inside the selected slave, shared by all of them
  assign offset = paddr_i[`PERIPH_OFFSET_W-1:0];

  ////////////////////
  // Bus decoder
  ////////////////////

  periph_bus u_periph_bus (
    .paddr_i        (paddr_i),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .gpp_pready_i   (gpp_pready_i),
    .gpp_pslverr_i  (gpp_pslverr_i),
    .gpio_prdata_i  (gpio_prdata),
    .timer_prdata_i (timer_prdata),
    .event_prdata_i (event_prdata),
    .soc_prdata_i   (soc_prdata),
    .gpp_prdata_i   (gpp_prdata_i),
    .gpio_psel_o    (gpio_psel),
    .timer_psel_o   (timer_psel),
    .event_psel_o   (event_psel),
    .soc_psel_o     (soc_psel),
    .gpp_psel_o     (gpp_psel),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o)
  );

  ////////////////////
  // Internal slaves
  ////////////////////

  apb_gpio u_apb_gpio (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .en_i       (clk_gate[`PERIPH_CG_GPIO]),
    .psel_i     (gpio_psel),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (offset),
    .pwdata_i   (pwdata_i),
    .gpio_in_i  (gpio_in_i),
    .prdata_o   (gpio_prdata),
    .gpio_out_o (gpio_out_o),
    .gpio_dir_o (gpio_dir_o),
    .event_o    (gpio_event)
  );

  apb_timer u_apb_timer (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .en_i      (clk_gate[`PERIPH_CG_TIMER]),
    .psel_i    (timer_psel),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (offset),
    .pwdata_i  (pwdata_i),
    .prdata_o  (timer_prdata),
    .event_o   (timer_event)
  );

  // Event sources: timer on 31, GPIO on 30, rest tied low
  always_comb begin
    event_src                    = '0;
    event_src[`PERIPH_IRQ_TIMER] = timer_event;
    event_src[`PERIPH_IRQ_GPIO]  = gpio_event;
  end

  apb_event_unit u_apb_event_unit (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .psel_i    (event_psel),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (offset),
    .pwdata_i  (pwdata_i),
    .events_i  (event_src),
    .prdata_o  (event_prdata),
    .irq_o     (irq_o)
  );

  apb_soc_ctrl u_apb_soc_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .psel_i      (soc_psel),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (offset),
    .pwdata_i    (pwdata_i),
    .prdata_o    (soc_prdata),
    .pad_mux_o   (pad_mux_o),
    .clk_gate_o  (clk_gate),
    .boot_addr_o (boot_addr_o)
  );

  ////////////////////
  // General purpose port
  ////////////////////

  // Request side is the APB input, qualified by the GPP select
  assign gpp_paddr_o   = offset;
  assign gpp_pwdata_o  = pwdata_i;
  assign gpp_pwrite_o  = pwrite_i;
  assign gpp_psel_o    = gpp_psel;
  assign gpp_penable_o = gpp_psel & penable_i;
  assign gpp_clk_en_o  = clk_gate[`PERIPH_CG_GPP];

endmodule

//--- testbench/tb_peripherals.sv
`timescale 1ns/1ps

`include "periph_macros.svh"

module tb_peripherals import periph_pkg::*; ();

  localparam int CLK_HALF      = 50;
  localparam int READY_TIMEOUT = 32;
  localparam int IRQ_TIMEOUT   = 400;

  // DUT inputs
  logic        clk;
  logic        rst;
  apb_addr_t   paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  reg_word_t   pwdata;
  reg_word_t   gpio_in;
  reg_word_t   gpp_prdata  = '0;
  logic        gpp_pready  = 1'b0;
  logic        gpp_pslverr = 1'b0;

  // DUT outputs
  reg_word_t   prdata;
  logic        pready;
  logic        pslverr;
  reg_word_t   gpio_out;
  reg_word_t   gpio_dir;
  reg_word_t   irq;
  reg_word_t   pad_mux;
  reg_word_t   boot_addr;
  reg_offset_t gpp_paddr;
  reg_word_t   gpp_pwdata;
  logic        gpp_pwrite;
  logic        gpp_psel;
  logic        gpp_penable;
  logic        gpp_clk_en;

  integer      seed;

  // Register model
  reg_word_t   m_padmux;
  reg_word_t   m_clkgate;
  reg_word_t   m_bootaddr;
  reg_word_t   m_gpio_dir;
  reg_word_t   m_gpio_out;
  reg_word_t   m_timer_cmp;
  reg_word_t   m_ier;

  // GPP slave answer for the next transfer
  int          gpp_wait_cfg  = 0;
  int          gpp_wait_cnt  = 0;
  reg_word_t   gpp_rdata_cfg = '0;
  logic        gpp_err_cfg   = 1'b0;
  // Request the GPP should see
  reg_offset_t gpp_exp_addr  = '0;
  reg_word_t   gpp_exp_wdata = '0;
  logic        gpp_exp_write = 1'b0;

  peripherals u_peripherals (
    .clk_i         (clk),
    .rst_i         (rst),
    .paddr_i       (paddr),
    .psel_i        (psel),
    .penable_i     (penable),
    .pwrite_i      (pwrite),
    .pwdata_i      (pwdata),
    .prdata_o      (prdata),
    .pready_o      (pready),
    .pslverr_o     (pslverr),
    .gpio_in_i     (gpio_in),
    .gpio_out_o    (gpio_out),
    .gpio_dir_o    (gpio_dir),
    .irq_o         (irq),
    .pad_mux_o     (pad_mux),
    .boot_addr_o   (boot_addr),
    .gpp_paddr_o   (gpp_paddr),
    .gpp_pwdata_o  (gpp_pwdata),
    .gpp_pwrite_o  (gpp_pwrite),
    .gpp_psel_o    (gpp_psel),
    .gpp_penable_o (gpp_penable),
    .gpp_clk_en_o  (gpp_clk_en),
    .gpp_prdata_i  (gpp_prdata),
    .gpp_pready_i  (gpp_pready),
    .gpp_pslverr_i (gpp_pslverr)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #CLK_HALF clk = ~clk;
    end
  end

  ////////////////////
  // Checking helpers
  ////////////////////

  task automatic stop_failed(input string why);
    $display("Regression failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check(input reg_word_t actual, input reg_word_t expected, input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
      stop_failed("a checked value did not match the model");
    end
  endtask

  // Slave index in bits 14:12 with the offset below
  function automatic apb_addr_t reg_addr(input logic [2:0] slave, input reg_offset_t off);
    return {slave, off};
  endfunction

  ////////////////////
  // APB master
  ////////////////////

  // Called at an edge inside the access phase
  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!pready) begin
      cycles++;
      if (cycles > READY_TIMEOUT) begin
        stop_failed("timeout: pready never came back during an APB access");
      end
      @(posedge clk);
    end
  endtask

  task automatic apb_write(input apb_addr_t addr, input reg_word_t data, output logic err);
    @(posedge clk);
    paddr   <= addr;
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    wait_ready();
    err = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output reg_word_t data, output logic err);
    @(posedge clk);
    paddr   <= addr;
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    pwdata  <= '0;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    wait_ready();
    // Sampled at the completing edge before any register update lands
    data = prdata;
    err  = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_ok(input apb_addr_t addr, input reg_word_t data);
    logic err;
    apb_write(addr, data, err);
    check(32'(err), 32'd0, "pslverr on internal write");
  endtask

  task automatic read_expect(input apb_addr_t addr, input reg_word_t expected,
                             input string what);
    reg_word_t data;
    logic      err;
    apb_read(addr, data, err);
    check(32'(err), 32'd0, "pslverr on internal read");
    check(data, expected, what);
  endtask

  task automatic wait_irq(input int bit_idx);
    int cycles;
    cycles = 0;
    while (!irq[bit_idx]) begin
      cycles++;
      if (cycles > IRQ_TIMEOUT) begin
        stop_failed("timeout: the expected irq line never rose");
      end
      @(posedge clk);
    end
  endtask

  ////////////////////
  // GPP slave model
  ////////////////////

  // Setup cycle loads the answer and access cycles count down the wait states
  always @(posedge clk) begin
    if (rst) begin
      gpp_pready   <= 1'b0;
      gpp_prdata   <= '0;
      gpp_pslverr  <= 1'b0;
      gpp_wait_cnt <= 0;
    end else if (gpp_psel && !gpp_penable) begin
      gpp_wait_cnt <= gpp_wait_cfg;
      gpp_pready   <= (gpp_wait_cfg == 0);
      gpp_prdata   <= gpp_rdata_cfg;
      gpp_pslverr  <= gpp_err_cfg;
    end else if (gpp_psel && !gpp_pready) begin
      gpp_wait_cnt <= gpp_wait_cnt - 1;
      gpp_pready   <= (gpp_wait_cnt == 1);
    end else begin
      gpp_pready <= 1'b0;
    end
  end

  // Request fields must be stable for the whole GPP transfer
  always @(posedge clk) begin
    if (!rst && gpp_psel) begin
      check(32'(gpp_paddr), 32'(gpp_exp_addr), "gpp_paddr_o");
      check(gpp_pwdata, gpp_exp_wdata, "gpp_pwdata_o");
      check(32'(gpp_pwrite), 32'(gpp_exp_write), "gpp_pwrite_o");
      check(32'(gpp_penable), 32'(penable), "gpp_penable_o");
      // Transfer may only end when the GPP slave is ready
      check(32'(pready), 32'(gpp_pready), "pready_o during GPP transfer");
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    apb_addr_t  addr;
    reg_word_t  data;
    reg_word_t  value;
    reg_word_t  mask;
    reg_word_t  first_count;
    logic       err;
    int         choice;
    int         pin;

    seed    = 32'heda5f2f8;
    rst     <= 1'b1;
    paddr   <= '0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    pwdata  <= '0;
    gpio_in <= '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    m_padmux    = '0;
    m_clkgate   = '1;
    m_bootaddr  = `PERIPH_BOOT_ADDR_RST;
    m_gpio_dir  = '0;
    m_gpio_out  = '0;
    m_timer_cmp = '0;
    m_ier       = '0;

    // Reset values
    read_expect(reg_addr(sel_socctrl, `PERIPH_SOC_BOOTADDR), m_bootaddr, "BOOTADDR reset");
    read_expect(reg_addr(sel_socctrl, `PERIPH_SOC_CLKGATE), m_clkgate, "CLKGATE reset");
    read_expect(reg_addr(sel_socctrl, `PERIPH_SOC_PADMUX), m_padmux, "PADMUX reset");
    check(irq, 32'd0, "irq_o after reset");
    check(gpio_out, 32'd0, "gpio_out_o after reset");
    check(gpio_dir, 32'd0, "gpio_dir_o after reset");
    check(32'(pslverr), 32'd0, "pslverr_o after reset");
    check(32'(gpp_psel), 32'd0, "gpp_psel_o after reset");
    check(32'(gpp_penable), 32'd0, "gpp_penable_o after reset");
    check(32'(gpp_clk_en), 32'd1, "gpp_clk_en_o after reset");

    // Random register traffic with one model register per write
    for (int i = 0; i < 48; i++) begin
      choice = $unsigned($random(seed)) % 6;
      value  = $random(seed);
      case (choice)
        0: begin
          addr     = reg_addr(sel_socctrl, `PERIPH_SOC_PADMUX);
          m_padmux = value;
        end
        1: begin
          addr       = reg_addr(sel_socctrl, `PERIPH_SOC_BOOTADDR);
          m_bootaddr = value;
        end
        2: begin
          addr       = reg_addr(sel_gpio, `PERIPH_GPIO_DIR);
          m_gpio_dir = value;
        end
        3: begin
          addr       = reg_addr(sel_gpio, `PERIPH_GPIO_OUT);
          m_gpio_out = value;
        end
        4: begin
          addr        = reg_addr(sel_timer, `PERIPH_TIMER_CMP);
          m_timer_cmp = value;
        end
        default: begin
          addr  = reg_addr(sel_event, `PERIPH_EVENT_IER);
          m_ier = value;
        end
      endcase
      write_ok(addr, value);
      read_expect(addr, value, "read-back after random write");
      check(pad_mux, m_padmux, "pad_mux_o");
      check(boot_addr, m_bootaddr, "boot_addr_o");
      check(gpio_out, m_gpio_out, "gpio_out_o");
      check(gpio_dir, m_gpio_dir, "gpio_dir_o");
    end

    // Unmapped slave indices end in an error with zero data
    for (int idx = 5; idx < 8; idx++) begin
      apb_read(reg_addr(3'(idx), 12'h004), data, err);
      check(32'(err), 32'd1, "pslverr on unmapped read");
      check(data, 32'd0, "prdata on unmapped read");
      apb_write(reg_addr(3'(idx), 12'h008), $random(seed), err);
      check(32'(err), 32'd1, "pslverr on unmapped write");
    end

    // GPP transfers with random wait states, data and error
    for (int i = 0; i < 16; i++) begin
      gpp_wait_cfg  = $unsigned($random(seed)) % 4;
      gpp_rdata_cfg = $random(seed);
      value         = $random(seed);
      gpp_err_cfg   = value[0];
      gpp_exp_addr  = {value[11:2], 2'b00};
      gpp_exp_write = value[12];
      gpp_exp_wdata = gpp_exp_write ? $random(seed) : 32'd0;
      if (gpp_exp_write) begin
        apb_write(reg_addr(sel_gpp, gpp_exp_addr), gpp_exp_wdata, err);
      end else begin
        apb_read(reg_addr(sel_gpp, gpp_exp_addr), data, err);
        check(data, gpp_rdata_cfg, "GPP read data");
      end
      check(32'(err), 32'(gpp_err_cfg), "GPP pslverr");
      // Let the select drop before the next request is set up
      @(posedge clk);
    end

    // Timer compare event into irq bit 31
    value       = $random(seed);
    // Period of at least four cycles so a running count differs across two reads
    m_timer_cmp = {29'd0, value[2:0]} + 32'd3;
    write_ok(reg_addr(sel_timer, `PERIPH_TIMER_CMP), m_timer_cmp);
    write_ok(reg_addr(sel_timer, `PERIPH_TIMER_COUNT), 32'd0);
    m_ier = 32'd1 << `PERIPH_IRQ_TIMER;
    write_ok(reg_addr(sel_event, `PERIPH_EVENT_IER), m_ier);
    write_ok(reg_addr(sel_timer, `PERIPH_TIMER_CTRL), 32'd1);
    wait_irq(`PERIPH_IRQ_TIMER);
    // Stop first so no new compare refills the pending bit
    write_ok(reg_addr(sel_timer, `PERIPH_TIMER_CTRL), 32'd0);
    write_ok(reg_addr(sel_event, `PERIPH_EVENT_ICP), m_ier);
    apb_read(reg_addr(sel_event, `PERIPH_EVENT_IPR), data, err);
    check(data & m_ier, 32'd0, "IPR bit 31 after ICP");

    // Gated timer holds its count while still running
    write_ok(reg_addr(sel_timer, `PERIPH_TIMER_CTRL), 32'd1);
    m_clkgate = ~(32'd1 << `PERIPH_CG_TIMER);
    write_ok(reg_addr(sel_socctrl, `PERIPH_SOC_CLKGATE), m_clkgate);
    apb_read(reg_addr(sel_timer, `PERIPH_TIMER_COUNT), first_count, err);
    read_expect(reg_addr(sel_timer, `PERIPH_TIMER_COUNT), first_count, "frozen COUNT");
    check(32'(gpp_clk_en), 32'd1, "gpp_clk_en_o with timer gated");
    write_ok(reg_addr(sel_timer, `PERIPH_TIMER_CTRL), 32'd0);
    m_clkgate = '1;
    write_ok(reg_addr(sel_socctrl, `PERIPH_SOC_CLKGATE), m_clkgate);
    write_ok(reg_addr(sel_event, `PERIPH_EVENT_ICP), 32'd1 << `PERIPH_IRQ_TIMER);

    // GPIO rising edge into irq bit 30
    value = $random(seed);
    pin   = int'(value[4:0]);
    mask  = 32'd1 << pin;
    write_ok(reg_addr(sel_gpio, `PERIPH_GPIO_INTEN), mask);
    m_ier = 32'd1 << `PERIPH_IRQ_GPIO;
    write_ok(reg_addr(sel_event, `PERIPH_EVENT_IER), m_ier);
    @(posedge clk);
    gpio_in <= mask;
    wait_irq(`PERIPH_IRQ_GPIO);
    read_expect(reg_addr(sel_gpio, `PERIPH_GPIO_INTSTATUS), mask, "INTSTATUS single pin");
    read_expect(reg_addr(sel_gpio, `PERIPH_GPIO_IN), mask, "synchronized GPIO input");
    write_ok(reg_addr(sel_gpio, `PERIPH_GPIO_INTSTATUS), mask);
    read_expect(reg_addr(sel_gpio, `PERIPH_GPIO_INTSTATUS), 32'd0, "INTSTATUS after clear");
    write_ok(reg_addr(sel_event, `PERIPH_EVENT_ICP), m_ier);
    apb_read(reg_addr(sel_event, `PERIPH_EVENT_IPR), data, err);
    check(data & m_ier, 32'd0, "IPR bit 30 after ICP");

    // Software set and clear with the hardware lines kept out
    for (int i = 0; i < 6; i++) begin
      m_ier = $random(seed);
      write_ok(reg_addr(sel_event, `PERIPH_EVENT_IER), m_ier);
      mask = $random(seed) & 32'h3FFF_FFFF;
      write_ok(reg_addr(sel_event, `PERIPH_EVENT_IPS), mask);
      read_expect(reg_addr(sel_event, `PERIPH_EVENT_IPR), mask, "IPR after IPS");
      check(irq, mask & m_ier, "irq_o after IPS");
      write_ok(reg_addr(sel_event, `PERIPH_EVENT_ICP), mask);
      read_expect(reg_addr(sel_event, `PERIPH_EVENT_IPR), 32'd0, "IPR after ICP");
    end

    $display("Regression passed");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+verilog
verilog/periph_pkg.sv
verilog/periph_bus.sv
verilog/apb_gpio.sv
verilog/apb_timer.sv
verilog/apb_event_unit.sv
verilog/apb_soc_ctrl.sv
verilog/peripherals.sv
testbench/tb_peripherals.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_peripherals
BUILD_DIR ?= build
FILELIST  ?= filelist.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --timescale 1ns/1ps -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
